//--- src/dm_pkg.sv
`default_nettype none

package dm_pkg;

   // Bus and host stream widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int HOST_WIDTH = 16;

   // Opcode field in the low bits of the first frame word
   localparam int OP_WIDTH = 4;

   // Read frame is op, addr hi, addr lo
   // Write frame adds data hi, data lo
   typedef enum logic [OP_WIDTH-1:0] {
      OP_READ  = 4'd1,
      OP_WRITE = 4'd2
   } dbg_op_e;

   // First word of every response
   typedef enum logic [HOST_WIDTH-1:0] {
      STAT_OK      = 16'h0001,
      STAT_BUS_ERR = 16'h0002,
      STAT_BAD_OP  = 16'h0003
   } dm_status_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

endpackage

`default_nettype wire

//--- src/wb_channel.sv
`timescale 1ns/100ps
`default_nettype none

// Wishbone classic, full-word accesses only
interface wb_channel import dm_pkg::*; ();

   logic                  cyc;
   logic                  stb;
   logic                  we;
   logic [ADDR_WIDTH-1:0] adr;
   logic [DATA_WIDTH-1:0] dat_m2s;
   logic [DATA_WIDTH-1:0] dat_s2m;
   logic                  ack;
   logic                  err;

   modport master (
      output cyc, stb, we, adr, dat_m2s,
      input  dat_s2m, ack, err
   );

   modport slave (
      input  cyc, stb, we, adr, dat_m2s,
      output dat_s2m, ack, err
   );

endinterface

`default_nettype wire

//--- src/nasti_channel.sv
`timescale 1ns/100ps
`default_nettype none

// Single-beat AXI, no IDs or burst fields
interface nasti_channel import dm_pkg::*; ();

   logic [ADDR_WIDTH-1:0] aw_addr;
   logic                  aw_valid;
   logic                  aw_ready;

   logic [DATA_WIDTH-1:0] w_data;
   logic                  w_valid;
   logic                  w_ready;

   axi_resp_e             b_resp;
   logic                  b_valid;
   logic                  b_ready;

   logic [ADDR_WIDTH-1:0] ar_addr;
   logic                  ar_valid;
   logic                  ar_ready;

   logic [DATA_WIDTH-1:0] r_data;
   axi_resp_e             r_resp;
   logic                  r_valid;
   logic                  r_ready;

   modport master (
      output aw_addr, aw_valid, w_data, w_valid, b_ready, ar_addr, ar_valid, r_ready,
      input  aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
   );

   modport slave (
      input  aw_addr, aw_valid, w_data, w_valid, b_ready, ar_addr, ar_valid, r_ready,
      output aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
   );

endinterface

`default_nettype wire

//--- src/dbg_cmd_unit.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_cmd_unit import dm_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [HOST_WIDTH-1:0] in_data_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output logic [HOST_WIDTH-1:0] out_data_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i,
   wb_channel.master             wb
);

   typedef enum logic [3:0] {
      IDLE, ADDR_HI, ADDR_LO, DATA_HI, DATA_LO, BUS, RESP_STAT, RESP_HI, RESP_LO
   } state_e;

   state_e                state_q;
   logic                  we_q;
   logic                  cyc_q;
   logic                  stb_q;
   logic [ADDR_WIDTH-1:0] addr_q;
   logic [DATA_WIDTH-1:0] wdata_q;
   logic [DATA_WIDTH-1:0] rdata_q;
   dm_status_e            status_q;
   logic                  in_fire;
   logic                  out_fire;
   logic                  bus_done;

   // Frame words are only taken while parsing
   assign in_ready_o  = state_q inside {IDLE, ADDR_HI, ADDR_LO, DATA_HI, DATA_LO};
   assign out_valid_o = state_q inside {RESP_STAT, RESP_HI, RESP_LO};
   assign in_fire     = in_valid_i & in_ready_o;
   assign out_fire    = out_valid_o & out_ready_i;
   assign bus_done    = cyc_q & (wb.ack | wb.err);

   assign wb.cyc     = cyc_q;
   assign wb.stb     = stb_q;
   assign wb.we      = we_q;
   assign wb.adr     = addr_q;
   assign wb.dat_m2s = wdata_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         we_q    <= 1'b0;
         cyc_q   <= 1'b0;
         stb_q   <= 1'b0;
      end else begin
         case (state_q)
            IDLE: if (in_fire) begin
               case (dbg_op_e'(in_data_i[OP_WIDTH-1:0]))
                  OP_READ: begin
                     we_q    <= 1'b0;
                     state_q <= ADDR_HI;
                  end
                  OP_WRITE: begin
                     we_q    <= 1'b1;
                     state_q <= ADDR_HI;
                  end
                  // Unknown opcode, answer right away
                  default: state_q <= RESP_STAT;
               endcase
            end
            ADDR_HI: if (in_fire) state_q <= ADDR_LO;
            ADDR_LO: if (in_fire) begin
               if (we_q) begin
                  state_q <= DATA_HI;
               end else begin
                  state_q <= BUS;
                  cyc_q   <= 1'b1;
                  stb_q   <= 1'b1;
               end
            end
            DATA_HI: if (in_fire) state_q <= DATA_LO;
            DATA_LO: if (in_fire) begin
               state_q <= BUS;
               cyc_q   <= 1'b1;
               stb_q   <= 1'b1;
            end
            BUS: if (bus_done) begin
               state_q <= RESP_STAT;
               cyc_q   <= 1'b0;
               stb_q   <= 1'b0;
            end
            // Data words follow only a good read
            RESP_STAT: if (out_fire) begin
               state_q <= (status_q == STAT_OK && !we_q) ? RESP_HI : IDLE;
            end
            RESP_HI: if (out_fire) state_q <= RESP_LO;
            RESP_LO: if (out_fire) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // Frame assembly and bus result capture
   always_ff @(posedge clk_i) begin
      if (in_fire) begin
         case (state_q)
            // Overwritten by the bus result for a valid opcode
            IDLE:    status_q <= STAT_BAD_OP;
            ADDR_HI: addr_q[ADDR_WIDTH-1:HOST_WIDTH] <= in_data_i;
            ADDR_LO: addr_q[HOST_WIDTH-1:0] <= in_data_i;
            DATA_HI: wdata_q[DATA_WIDTH-1:HOST_WIDTH] <= in_data_i;
            DATA_LO: wdata_q[HOST_WIDTH-1:0] <= in_data_i;
            default: ;
         endcase
      end
      if (bus_done) begin
         status_q <= wb.err ? STAT_BUS_ERR : STAT_OK;
         rdata_q  <= wb.dat_s2m;
      end
   end

   always_comb begin
      case (state_q)
         RESP_STAT: out_data_o = status_q;
         RESP_HI:   out_data_o = rdata_q[DATA_WIDTH-1:HOST_WIDTH];
         RESP_LO:   out_data_o = rdata_q[HOST_WIDTH-1:0];
         default:   out_data_o = '0;
      endcase
   end

   // Response word holds under back-pressure
   a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb.stb |-> wb.cyc);

endmodule

`default_nettype wire

//--- src/wb2axi.sv
`timescale 1ns/100ps
`default_nettype none

module wb2axi import dm_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   wb_channel.slave    wb,
   nasti_channel.master axi
);

   typedef enum logic [2:0] {
      IDLE, WR_ADDR, WR_RESP, RD_ADDR, RD_DATA, DONE
   } state_e;

   state_e                state_q;
   logic                  aw_valid_q;
   logic                  w_valid_q;
   logic                  ar_valid_q;
   logic                  ack_q;
   logic                  err_q;
   logic [DATA_WIDTH-1:0] rdata_q;
   logic                  aw_done;
   logic                  w_done;

   // Request fields stay stable for the whole Wishbone cycle
   assign axi.aw_addr  = wb.adr;
   assign axi.w_data   = wb.dat_m2s;
   assign axi.ar_addr  = wb.adr;
   assign axi.aw_valid = aw_valid_q;
   assign axi.w_valid  = w_valid_q;
   assign axi.ar_valid = ar_valid_q;
   assign axi.b_ready  = (state_q == WR_RESP);
   assign axi.r_ready  = (state_q == RD_DATA);

   assign wb.ack     = ack_q;
   assign wb.err     = err_q;
   assign wb.dat_s2m = rdata_q;

   // Each channel is finished once its valid is gone or handshaking now
   assign aw_done = !aw_valid_q || axi.aw_ready;
   assign w_done  = !w_valid_q || axi.w_ready;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         ar_valid_q <= 1'b0;
         ack_q      <= 1'b0;
         err_q      <= 1'b0;
      end else begin
         case (state_q)
            IDLE: if (wb.cyc && wb.stb) begin
               if (wb.we) begin
                  aw_valid_q <= 1'b1;
                  w_valid_q  <= 1'b1;
                  state_q    <= WR_ADDR;
               end else begin
                  ar_valid_q <= 1'b1;
                  state_q    <= RD_ADDR;
               end
            end
            WR_ADDR: begin
               if (axi.aw_ready) aw_valid_q <= 1'b0;
               if (axi.w_ready) w_valid_q <= 1'b0;
               if (aw_done && w_done) state_q <= WR_RESP;
            end
            WR_RESP: if (axi.b_valid) begin
               ack_q   <= (axi.b_resp != RESP_SLVERR);
               err_q   <= (axi.b_resp == RESP_SLVERR);
               state_q <= DONE;
            end
            RD_ADDR: if (axi.ar_ready) begin
               ar_valid_q <= 1'b0;
               state_q    <= RD_DATA;
            end
            RD_DATA: if (axi.r_valid) begin
               ack_q   <= (axi.r_resp != RESP_SLVERR);
               err_q   <= (axi.r_resp == RESP_SLVERR);
               state_q <= DONE;
            end
            // Single-cycle ack or err, master drops cyc after it
            DONE: begin
               ack_q   <= 1'b0;
               err_q   <= 1'b0;
               state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (axi.r_valid && axi.r_ready) rdata_q <= axi.r_data;
   end

   a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(wb.ack && wb.err));

   // Termination only inside a live master cycle
   a_term_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wb.ack || wb.err) |-> (wb.cyc && wb.stb));

endmodule

`default_nettype wire

//--- src/axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

module axi_mem import dm_pkg::*; #(
   parameter int MEM_WORDS = 1024
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   nasti_channel.slave axi
);

   localparam int IDX_WIDTH = $clog2(MEM_WORDS);

   logic [DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];
   logic                  aw_ready_q;
   logic                  ar_ready_q;
   logic                  b_valid_q;
   logic                  r_valid_q;
   axi_resp_e             b_resp_q;
   axi_resp_e             r_resp_q;
   logic [DATA_WIDTH-1:0] r_data_q;
   logic                  wr_in_range;
   logic                  rd_in_range;
   logic                  wr_fire;
   logic                  rd_fire;

   // Word index is the byte address without its two low bits
   assign wr_in_range = (axi.aw_addr >> 2) < ADDR_WIDTH'(MEM_WORDS);
   assign rd_in_range = (axi.ar_addr >> 2) < ADDR_WIDTH'(MEM_WORDS);

   // aw and w are accepted in the same cycle
   assign wr_fire = axi.aw_valid & axi.w_valid & aw_ready_q;
   assign rd_fire = axi.ar_valid & ar_ready_q;

   assign axi.aw_ready = aw_ready_q;
   assign axi.w_ready  = aw_ready_q;
   assign axi.b_valid  = b_valid_q;
   assign axi.b_resp   = b_resp_q;
   assign axi.ar_ready = ar_ready_q;
   assign axi.r_valid  = r_valid_q;
   assign axi.r_resp   = r_resp_q;
   assign axi.r_data   = r_data_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         aw_ready_q <= 1'b0;
         ar_ready_q <= 1'b0;
         b_valid_q  <= 1'b0;
         r_valid_q  <= 1'b0;
         b_resp_q   <= RESP_OKAY;
         r_resp_q   <= RESP_OKAY;
         r_data_q   <= '0;
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else begin
         // Write path
         if (wr_fire) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b1;
            b_resp_q   <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
            if (wr_in_range) mem[axi.aw_addr[IDX_WIDTH+1:2]] <= axi.w_data;
         end else if (axi.aw_valid && axi.w_valid && !aw_ready_q && !b_valid_q) begin
            aw_ready_q <= 1'b1;
         end
         if (b_valid_q && axi.b_ready) b_valid_q <= 1'b0;

         // Read path, out of range reads return zero
         if (rd_fire) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b1;
            r_resp_q   <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
            r_data_q   <= rd_in_range ? mem[axi.ar_addr[IDX_WIDTH+1:2]] : '0;
         end else if (axi.ar_valid && !ar_ready_q && !r_valid_q) begin
            ar_ready_q <= 1'b1;
         end
         if (r_valid_q && axi.r_ready) r_valid_q <= 1'b0;
      end
   end

   // Master offers no new write while the response is pending
   a_no_aw_while_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      axi.b_valid |-> !axi.aw_valid);

endmodule

`default_nettype wire

//--- src/dm_system_top.sv
`timescale 1ns/100ps
`default_nettype none

module dm_system_top import dm_pkg::*; #(
   parameter int MEM_WORDS = 1024
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // Host command stream
   input  logic [HOST_WIDTH-1:0] host_in_data_i,
   input  logic                  host_in_valid_i,
   output logic                  host_in_ready_o,

   // Host response stream
   output logic [HOST_WIDTH-1:0] host_out_data_o,
   output logic                  host_out_valid_o,
   input  logic                  host_out_ready_i
);

   wb_channel    c_wb_mem();
   nasti_channel c_axi_mem();

   dbg_cmd_unit u_dbg_cmd_unit (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_data_i   (host_in_data_i),
      .in_valid_i  (host_in_valid_i),
      .in_ready_o  (host_in_ready_o),
      .out_data_o  (host_out_data_o),
      .out_valid_o (host_out_valid_o),
      .out_ready_i (host_out_ready_i),
      .wb          (c_wb_mem)
   );

   // Wishbone to AXI for the memory
   wb2axi u_wb2axi_mem (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wb      (c_wb_mem),
      .axi     (c_axi_mem)
   );

   axi_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) u_axi_mem (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .axi     (c_axi_mem)
   );

endmodule

`default_nettype wire

//--- verif/tb_dm_system.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dm_system import dm_pkg::*; ();

   localparam int          MEM_WORDS = 1024;
   localparam int          TIMEOUT   = 200;
   localparam logic [31:0] LFSR_SEED = 32'hebb2733f;

   logic                  clk;
   logic                  rst_n;
   logic [HOST_WIDTH-1:0] host_in_data;
   logic                  host_in_valid;
   logic                  host_in_ready;
   logic [HOST_WIDTH-1:0] host_out_data;
   logic                  host_out_valid;
   logic                  host_out_ready;

   logic [31:0]           lfsr_state;
   logic [DATA_WIDTH-1:0] model_mem [logic [31:0]];
   bit                    stress;
   bit                    timed_out;
   int                    pass_cnt;
   int                    err_cnt;

   dm_system_top #(
      .MEM_WORDS (MEM_WORDS)
   ) i_dm_system_top (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .host_in_data_i   (host_in_data),
      .host_in_valid_i  (host_in_valid),
      .host_in_ready_o  (host_in_ready),
      .host_out_data_o  (host_out_data),
      .host_out_valid_o (host_out_valid),
      .host_out_ready_i (host_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check_status(input string name, input dm_status_e exp, input dm_status_e act);
      if (act === exp) begin
         pass_cnt++;
      end else begin
         err_cnt++;
         $display("Error %s: expected %h (%s) actual %h", name, exp, exp.name(), act);
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                             input logic [DATA_WIDTH-1:0] act);
      if (act === exp) begin
         pass_cnt++;
      end else begin
         err_cnt++;
         $display("Error %s: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic note_timeout(input string what);
      $display("Timeout: no handshake on the %s within %0d cycles", what, TIMEOUT);
      timed_out = 1'b1;
   endtask

   // Entered and left just after a rising edge
   task automatic send_word(input logic [HOST_WIDTH-1:0] w);
      logic [31:0] r;
      int          waited;
      if (timed_out) return;
      r = '0;
      if (stress) begin
         take_bits(2, r);
      end
      repeat (int'(r[1:0])) begin
         host_in_valid <= 1'b0;
         @(posedge clk);
      end
      host_in_data  <= w;
      host_in_valid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!host_in_ready) begin
         if (waited == TIMEOUT) begin
            note_timeout("command word");
            host_in_valid <= 1'b0;
            return;
         end
         waited++;
         @(negedge clk);
      end
      @(posedge clk);
      host_in_valid <= 1'b0;
   endtask

   task automatic recv_word(input string what, output logic [HOST_WIDTH-1:0] w);
      logic [31:0] r;
      int          waited;
      bit          got;
      w = '0;
      if (timed_out) return;
      waited = 0;
      got    = 1'b0;
      while (!got) begin
         if (waited == TIMEOUT) begin
            note_timeout(what);
            host_out_ready <= 1'b0;
            return;
         end
         if (stress) begin
            take_bits(1, r);
            host_out_ready <= r[0];
         end else begin
            host_out_ready <= 1'b1;
         end
         @(negedge clk);
         if (host_out_valid && host_out_ready) begin
            w   = host_out_data;
            got = 1'b1;
         end
         waited++;
         @(posedge clk);
      end
      host_out_ready <= 1'b0;
   endtask

   // After the final response word the unit takes frames again
   task automatic check_idle(input string name);
      if (timed_out) return;
      @(negedge clk);
      if (host_in_ready && !host_out_valid) begin
         pass_cnt++;
      end else begin
         err_cnt++;
         $display("%s: DUT did not return to idle after the last response word", name);
      end
      @(posedge clk);
   endtask

   task automatic run_cmd(input string name, input logic [3:0] op, input logic [31:0] idx,
                          input logic [DATA_WIDTH-1:0] wdata);
      logic [31:0]           r;
      logic [ADDR_WIDTH-1:0] addr;
      logic [HOST_WIDTH-1:0] st_word;
      logic [HOST_WIDTH-1:0] hi;
      logic [HOST_WIDTH-1:0] lo;
      logic [DATA_WIDTH-1:0] exp_data;
      dm_status_e            exp_st;
      bit                    is_rd;
      bit                    is_wr;
      addr  = {idx[29:0], 2'b00};
      is_rd = (op == OP_READ);
      is_wr = (op == OP_WRITE);
      if (!is_rd && !is_wr) begin
         exp_st = STAT_BAD_OP;
      end else if (idx >= 32'(MEM_WORDS)) begin
         exp_st = STAT_BUS_ERR;
      end else begin
         exp_st = STAT_OK;
      end
      exp_data = model_mem.exists(idx) ? model_mem[idx] : '0;
      // Upper bits of the opcode word carry nothing
      take_bits(HOST_WIDTH - OP_WIDTH, r);
      send_word({r[HOST_WIDTH-OP_WIDTH-1:0], op});
      if (is_rd || is_wr) begin
         send_word(addr[31:16]);
         send_word(addr[15:0]);
      end
      if (is_wr) begin
         send_word(wdata[31:16]);
         send_word(wdata[15:0]);
      end
      recv_word("status word", st_word);
      if (timed_out) return;
      check_status({name, " status"}, exp_st, dm_status_e'(st_word));
      if (is_rd && exp_st == STAT_OK) begin
         recv_word("read data high half", hi);
         recv_word("read data low half", lo);
         if (timed_out) return;
         check_data({name, " data"}, exp_data, {hi, lo});
      end
      if (is_wr && exp_st == STAT_OK) begin
         model_mem[idx] = wdata;
      end
      check_idle(name);
   endtask

   task automatic pick_bad_op(output logic [3:0] op);
      logic [31:0] r;
      take_bits(OP_WIDTH, r);
      op = r[3:0];
      if (op == OP_READ || op == OP_WRITE) begin
         op = op ^ 4'h8;
      end
   endtask

   task automatic random_cmd(input string name, input bit any_kind);
      logic [31:0]           r;
      logic [31:0]           idx;
      logic [DATA_WIDTH-1:0] data;
      logic [3:0]            op;
      take_bits(2, r);
      op = r[0] ? 4'(OP_WRITE) : 4'(OP_READ);
      // Small window half the time so reads hit written words
      if (r[1]) begin
         take_bits(4, idx);
      end else begin
         take_bits(10, idx);
      end
      take_bits(DATA_WIDTH, data);
      if (any_kind) begin
         take_bits(3, r);
         if (r[2:0] == 3'd6) begin
            idx = idx | 32'(MEM_WORDS);
         end else if (r[2:0] == 3'd7) begin
            pick_bad_op(op);
         end
      end
      run_cmd(name, op, idx, data);
   endtask

   task automatic finish_test(input string name, input int chk0, input int err0);
      $display("test %-12s %0d checks, %0d errors", name, pass_cnt + err_cnt - chk0,
               err_cnt - err0);
   endtask

   initial begin
      int                    chk0;
      int                    err0;
      logic [31:0]           idx;
      logic [31:0]           k;
      logic [3:0]            op;
      logic [DATA_WIDTH-1:0] data;
      lfsr_state     = LFSR_SEED;
      stress         = 1'b0;
      timed_out      = 1'b0;
      pass_cnt       = 0;
      err_cnt        = 0;
      rst_n          = 1'b0;
      host_in_data   = '0;
      host_in_valid  = 1'b0;
      host_out_ready = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      chk0 = 0;
      err0 = 0;
      @(negedge clk);
      if (host_in_ready && !host_out_valid) begin
         pass_cnt++;
      end else begin
         err_cnt++;
         $display("reset_state: input not ready or output valid right after reset");
      end
      @(posedge clk);
      finish_test("reset_state", chk0, err0);

      chk0 = pass_cnt + err_cnt;
      err0 = err_cnt;
      for (int i = 0; i < 4 && !timed_out; i++) begin
         take_bits(10, idx);
         take_bits(DATA_WIDTH, data);
         run_cmd($sformatf("write_read %0d write", i), OP_WRITE, idx, data);
         run_cmd($sformatf("write_read %0d read", i), OP_READ, idx, '0);
      end
      finish_test("write_read", chk0, err0);

      chk0 = pass_cnt + err_cnt;
      err0 = err_cnt;
      for (int i = 0; i < 200 && !timed_out; i++) begin
         random_cmd($sformatf("random_mix %0d", i), 1'b0);
      end
      finish_test("random_mix", chk0, err0);

      // Out of range writes must not alias onto in-range words
      chk0 = pass_cnt + err_cnt;
      err0 = err_cnt;
      for (int i = 0; i < 8 && !timed_out; i++) begin
         take_bits(4, k);
         take_bits(DATA_WIDTH, data);
         run_cmd($sformatf("out_of_range %0d fill", i), OP_WRITE, k, data);
         if (i == 0) begin
            idx = 32'(MEM_WORDS);
         end else if ((i % 2) == 1) begin
            take_bits(30, idx);
            idx = idx | 32'(MEM_WORDS);
         end else begin
            idx = k | 32'(MEM_WORDS);
         end
         take_bits(DATA_WIDTH, data);
         run_cmd($sformatf("out_of_range %0d write", i), OP_WRITE, idx, data);
         run_cmd($sformatf("out_of_range %0d read", i), OP_READ, idx, '0);
         run_cmd($sformatf("out_of_range %0d check", i), OP_READ, k, '0);
      end
      finish_test("out_of_range", chk0, err0);

      chk0 = pass_cnt + err_cnt;
      err0 = err_cnt;
      for (int i = 0; i < 8 && !timed_out; i++) begin
         pick_bad_op(op);
         take_bits(10, idx);
         run_cmd($sformatf("bad_opcode %0d", i), op, idx, '0);
         random_cmd($sformatf("bad_opcode %0d next", i), 1'b0);
      end
      finish_test("bad_opcode", chk0, err0);

      chk0 = pass_cnt + err_cnt;
      err0 = err_cnt;
      stress = 1'b1;
      for (int i = 0; i < 100 && !timed_out; i++) begin
         random_cmd($sformatf("backpressure %0d", i), 1'b1);
      end
      stress = 1'b0;
      finish_test("backpressure", chk0, err0);

      $display("checks passed: %0d, failed: %0d", pass_cnt, err_cnt);
      if (timed_out || err_cnt != 0) begin
         $display("Simulation FAILED");
      end else begin
         $display("Simulation PASSED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
src/dm_pkg.sv
src/wb_channel.sv
src/nasti_channel.sv
src/dbg_cmd_unit.sv
src/wb2axi.sv
src/axi_mem.sv
src/dm_system_top.sv
verif/tb_dm_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log for a failure
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_dm_system -f list.f \
   && ./obj_dir/Vtb_dm_system 2>&1 | tee sim.log \
   && ! grep -q "Simulation FAILED" sim.log \
   && echo "Run passed" \
   || { echo "Run failed"; exit 1; }
